// ==== all.f ====
+incdir+hdl
hdl/blur_pkg.sv
hdl/pixel_mem.sv
hdl/row_line_buffer.sv
hdl/gauss_row_filter.sv
hdl/blur_ctrl.sv
hdl/blur_core.sv
verif/blur_tb.sv

// ==== Makefile ====
# Verilator flow for the blur core
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= blur_tb
RTL_TOP   ?= blur_core
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim build clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build: $(BIN)

$(BIN): $(FILELIST) hdl/*.sv hdl/*.svh verif/*.sv
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# the run status is ignored; the log decides pass or fail
sim: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/blur_tb.sv ====
`timescale 1ns/1ps
`include "blur_params.svh"

module blur_tb;

    localparam int rows = `BLUR_ROWS;
    localparam int cols = `BLUR_COLS;
    // prime plus three cycles per row plus drain and slack
    localparam int pass_cycles = 4 + 3 * rows + 4;
    // load + pass + readback with pipeline tail
    localparam int test_cycles = rows + 2 + pass_cycles + rows + 4;
    localparam int timeout_cycles = 2 * (4 * test_cycles) + 20;  // twice four full runs

    logic                     clk;
    logic                     rst_n;
    logic                     start;
    logic                     done;
    logic                     img_we;
    blur_pkg::row_addr_t      img_addr;
    blur_pkg::row_t           img_din;
    blur_pkg::row_addr_t      blur_raddr;
    blur_pkg::row_t           blur_dout;

    logic [`BLUR_PIX_W-1:0]   img [rows][cols];     // tb copy of the loaded image
    int                       seed = 59886;
    logic                     started = 1'b0;       // set with the first start pulse
    logic                     rd_check = 1'b0;      // read address issued this cycle
    logic [`BLUR_ROW_W-1:0]   exp_row = '0;
    logic                     rd_q = 1'b0;          // data due on this edge
    logic [`BLUR_ROW_W-1:0]   exp_q = '0;
    blur_pkg::row_addr_t      addr_q = '0;
    int                       checks_seen = 0;
    int                       cycle_cnt = 0;

    blur_core uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .done       (done),
        .img_we     (img_we),
        .img_addr   (img_addr),
        .img_din    (img_din),
        .blur_raddr (blur_raddr),
        .blur_dout  (blur_dout)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                      // 10 ns period
    end

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // zero padded 1-2-1 kernel with rounding to nearest
    function automatic int expected_pixel(int r, int c);
        int acc;
        int dr;
        int dc;
        int w;
        acc = 0;
        for (dr = -1; dr <= 1; dr++) begin
            for (dc = -1; dc <= 1; dc++) begin
                w = ((dr == 0) ? 2 : 1) * ((dc == 0) ? 2 : 1);
                if (r + dr >= 0 && r + dr < rows && c + dc >= 0 && c + dc < cols) begin
                    acc += w * int'(img[r + dr][c + dc]);
                end                                 // outside the image adds nothing
            end
        end
        return (acc + 8) / 16;
    endfunction

    function automatic logic [`BLUR_ROW_W-1:0] expected_row(int r);
        logic [`BLUR_ROW_W-1:0] row;
        int c;
        row = '0;
        // column 0 low
        for (c = 0; c < cols; c++) begin
            row[c * `BLUR_PIX_W +: `BLUR_PIX_W] = blur_pkg::pixel_t'(expected_pixel(r, c));
        end
        return row;
    endfunction

    function automatic void fill_random();
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                img[r][c] = blur_pkg::pixel_t'($random(seed));  // low byte kept
            end
        end
    endfunction

    // constant background with one marked pixel
    function automatic void fill_image(int bg, int pr, int pc, int pv);
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                img[r][c] = blur_pkg::pixel_t'((r == pr && c == pc) ? pv : bg);
            end
        end
    endfunction

    task automatic load_image();
        logic [`BLUR_ROW_W-1:0] row;
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                row[c * `BLUR_PIX_W +: `BLUR_PIX_W] = img[r][c];
            end
            @(posedge clk);
            img_we   <= 1'b1;
            img_addr <= blur_pkg::row_addr_t'(r);
            img_din  <= row;
        end
        @(posedge clk);
        img_we <= 1'b0;
    endtask

    // start pulse and wait for done on the falling edge
    task automatic run_blur();
        @(posedge clk);
        start   <= 1'b1;
        started <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        do @(negedge clk); while (!done);
    endtask

    task automatic read_back();
        for (int r = 0; r < rows; r++) begin
            @(posedge clk);
            blur_raddr <= blur_pkg::row_addr_t'(r);
            rd_check   <= 1'b1;
            exp_row    <= expected_row(r);
        end
        @(posedge clk);
        rd_check <= 1'b0;
        repeat (3) @(posedge clk);                  // let the last compare land
    endtask

    // compare pipeline one edge behind the read address
    always @(posedge clk) begin
        rd_q   <= rd_check;
        exp_q  <= exp_row;
        addr_q <= blur_raddr;
        if (rd_q) begin
            checks_seen <= checks_seen + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: done never arrived within %0d cycles", timeout_cycles);
            abort_run();
        end
    end

    a_done_low_before_start: assert property (
        @(posedge clk) disable iff (!rst_n) !started |-> !done
    ) else begin
        $display("FAIL t=%0t done expected 0 got %b before any start", $time, $sampled(done));
        abort_run();
    end

    a_done_drops: assert property (
        @(posedge clk) disable iff (!rst_n) (start && done) |=> !done
    ) else begin
        $display("FAIL t=%0t done expected 0 got %b after start", $time, $sampled(done));
        abort_run();
    end

    a_done_holds: assert property (
        @(posedge clk) disable iff (!rst_n) (done && !start) |=> done
    ) else begin
        $display("FAIL t=%0t done expected 1 got %b without start", $time, $sampled(done));
        abort_run();
    end

    a_readback: assert property (
        @(posedge clk) disable iff (!rst_n) rd_q |-> (blur_dout == exp_q)
    ) else begin
        $display("FAIL t=%0t blur_dout row %0d expected %h got %h",
                 $time, $sampled(addr_q), $sampled(exp_q), $sampled(blur_dout));
        abort_run();
    end

    initial begin
        rst_n      <= 1'b0;
        start      <= 1'b0;
        img_we     <= 1'b0;
        img_addr   <= '0;
        img_din    <= '0;
        blur_raddr <= '0;
        repeat (3) @(posedge clk);                  // reset held 3 cycles
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);                  // done must stay low here
        fill_random();
        load_image();
        run_blur();
        read_back();
        fill_image(255, -1, -1, 0);                 // flat white with border falloff
        load_image();
        run_blur();
        read_back();
        fill_image(0, 5, 7, 255);                   // impulse response
        load_image();
        run_blur();
        read_back();
        fill_random();                              // restart from st_end with new data
        load_image();
        run_blur();
        read_back();
        if (checks_seen == 4 * rows) begin
            $display("test passed");
            $finish;
        end else begin
            $display("only %0d of %0d readback rows were compared", checks_seen, 4 * rows);
            abort_run();
        end
    end

endmodule

// ==== hdl/blur_core.sv ====
`timescale 1ns/1ps

// gaussian smoothing front end, top level
module blur_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,              // host pulse
    output logic                done,               // all blurred rows stored
    input  logic                img_we,             // image load port
    input  blur_pkg::row_addr_t img_addr,
    input  blur_pkg::row_t      img_din,
    input  blur_pkg::row_addr_t blur_raddr,         // readback port
    output blur_pkg::row_t      blur_dout           // one cycle after blur_raddr
);

    blur_pkg::row_addr_t img_raddr;                 // ctrl -> image memory
    blur_pkg::row_t      img_row;                   // image memory -> window
    logic                shift_en;
    logic                shift_zero;
    blur_pkg::row_t      row_above;                 // window rows
    blur_pkg::row_t      row_mid;
    blur_pkg::row_t      row_below;
    logic                filt_valid;                // ctrl -> filter
    blur_pkg::row_addr_t filt_addr;
    logic                wr_en;                     // filter -> blurred memory
    blur_pkg::row_addr_t wr_addr;
    blur_pkg::row_t      wr_row;

    // source image, written by the host
    pixel_mem u_img_mem (
        .clk   (clk),
        .we    (img_we),
        .waddr (img_addr),
        .din   (img_din),
        .raddr (img_raddr),
        .dout  (img_row)
    );

    row_line_buffer u_line_buf (
        .clk        (clk),
        .rst_n      (rst_n),
        .shift_en   (shift_en),
        .shift_zero (shift_zero),
        .row_in     (img_row),
        .row_above  (row_above),
        .row_mid    (row_mid),
        .row_below  (row_below)
    );

    gauss_row_filter u_filter (
        .clk        (clk),
        .rst_n      (rst_n),
        .filt_valid (filt_valid),
        .filt_addr  (filt_addr),
        .row_above  (row_above),
        .row_mid    (row_mid),
        .row_below  (row_below),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_row     (wr_row)
    );

    // blurred result, read back by the host
    pixel_mem u_blur_mem (
        .clk   (clk),
        .we    (wr_en),
        .waddr (wr_addr),
        .din   (wr_row),
        .raddr (blur_raddr),
        .dout  (blur_dout)
    );

    blur_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .done       (done),
        .img_raddr  (img_raddr),
        .shift_en   (shift_en),
        .shift_zero (shift_zero),
        .filt_valid (filt_valid),
        .filt_addr  (filt_addr)
    );

endmodule

// ==== hdl/blur_ctrl.sv ====
`timescale 1ns/1ps
`include "blur_params.svh"

// sequences reads, window shifts and filter strobes for one image pass
module blur_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,              // one-cycle host pulse
    output logic                done,               // high only in st_end
    output blur_pkg::row_addr_t img_raddr,          // image memory read row
    output logic                shift_en,           // window shift
    output logic                shift_zero,         // shift in a border row
    output logic                filt_valid,         // window complete
    output blur_pkg::row_addr_t filt_addr           // row being blurred
);

    blur_pkg::ctrl_state_e state;
    blur_pkg::ctrl_state_e state_nxt;
    blur_pkg::row_addr_t   row_cnt;                 // current output row
    blur_pkg::row_addr_t   row_nxt;
    logic [1:0]            phase;                   // step within a row
    logic [1:0]            phase_nxt;
    logic                  last_row;                // bottom border next

    // blur phases: 0 read r+1, 1 shift, 2 strobe, 3 drain after last row
    // prime phases: 0 read row 0, 1 shift zeros, 2 shift row 0

    assign last_row = (row_cnt == blur_pkg::row_addr_t'(`BLUR_ROWS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= blur_pkg::st_idle;
            row_cnt <= '0;
            phase   <= '0;
        end else begin
            state   <= state_nxt;
            row_cnt <= row_nxt;
            phase   <= phase_nxt;
        end
    end

    // next state
    always_comb begin
        state_nxt = state;
        row_nxt   = row_cnt;
        phase_nxt = phase;
        case (state)
            blur_pkg::st_idle, blur_pkg::st_end: begin
                if (start) begin                    // restart allowed after done
                    state_nxt = blur_pkg::st_prime;
                    row_nxt   = '0;
                    phase_nxt = '0;
                end
            end
            blur_pkg::st_prime: begin
                phase_nxt = phase + 2'd1;
                if (phase == 2'd2) begin            // row 0 now at the bottom
                    state_nxt = blur_pkg::st_blur;
                    phase_nxt = '0;
                end
            end
            blur_pkg::st_blur: begin
                phase_nxt = phase + 2'd1;
                if (phase == 2'd2 && !last_row) begin
                    phase_nxt = '0;                 // on to next output row
                    row_nxt   = row_cnt + 1'b1;
                end
                if (phase == 2'd3) begin            // last write has landed
                    state_nxt = blur_pkg::st_end;
                    phase_nxt = '0;
                end
            end
            default: begin
                state_nxt = blur_pkg::st_idle;
            end
        endcase
    end

    // read address, held through the shift
    always_comb begin
        img_raddr = row_cnt;                        // row 0 while priming
        if (state == blur_pkg::st_blur && !last_row) begin
            img_raddr = row_cnt + 1'b1;             // row below the output row
        end
    end

    assign shift_en   = (state == blur_pkg::st_prime && phase != 2'd0)
                     || (state == blur_pkg::st_blur && phase == 2'd1);
    assign shift_zero = (state == blur_pkg::st_prime && phase == 2'd1)   // top border
                     || (state == blur_pkg::st_blur && phase == 2'd1 && last_row);
    assign filt_valid = (state == blur_pkg::st_blur && phase == 2'd2);
    assign filt_addr  = row_cnt;
    assign done       = (state == blur_pkg::st_end);

    // filter only sees a window that was just completed by a shift
    a_filt_after_shift: assert property (
        @(posedge clk) disable iff (!rst_n)
        filt_valid |-> (state == blur_pkg::st_blur) && $past(shift_en)
    ) else $error("blur_ctrl: filter strobe without a fresh window");

    // done must not rise while the last filter result is still in flight
    a_done_after_drain: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> (state == blur_pkg::st_end) && !$past(filt_valid)
    ) else $error("blur_ctrl: done outside st_end or before last write");

endmodule

// ==== hdl/gauss_row_filter.sv ====
`timescale 1ns/1ps
`include "blur_params.svh"

// 3x3 gaussian over one window, one blurred row per strobe
module gauss_row_filter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                filt_valid,         // window is ready
    input  blur_pkg::row_addr_t filt_addr,          // output row index
    input  blur_pkg::row_t      row_above,
    input  blur_pkg::row_t      row_mid,
    input  blur_pkg::row_t      row_below,
    output logic                wr_en,              // to blurred memory
    output blur_pkg::row_addr_t wr_addr,
    output blur_pkg::row_t      wr_row
);

    logic [`BLUR_COLS-1:0][9:0] col_sum;            // vertical 1-2-1, max 1020
    blur_pkg::row_t             blur_row;           // rounded result row

    genvar c;

    // vertical pass
    for (c = 0; c < `BLUR_COLS; c++) begin : g_vert
        assign col_sum[c] = 10'(row_above[c])
                          + 10'({row_mid[c], 1'b0}) // centre weight 2
                          + 10'(row_below[c]);
    end

    // horizontal pass, neighbours outside the row count as zero
    for (c = 0; c < `BLUR_COLS; c++) begin : g_horz
        logic [11:0] left_tap;                      // column c-1
        logic [11:0] right_tap;                     // column c+1
        logic [11:0] acc;                           // full kernel sum, max 4080
        logic [11:0] acc_rnd;                       // with rounding bias

        if (c == 0) begin : g_left_edge
            assign left_tap = '0;                   // left border
        end else begin : g_left
            assign left_tap = 12'(col_sum[c-1]);
        end

        if (c == `BLUR_COLS - 1) begin : g_right_edge
            assign right_tap = '0;                  // right border
        end else begin : g_right
            assign right_tap = 12'(col_sum[c+1]);
        end

        assign acc     = left_tap + 12'({col_sum[c], 1'b0}) + right_tap;
        assign acc_rnd = acc + 12'(1 << (`BLUR_KERNEL_SHIFT - 1));  // +8, round half up

        // normalise by kernel sum, always fits a pixel
        assign blur_row[c] = blur_pkg::pixel_t'(acc_rnd >> `BLUR_KERNEL_SHIFT);
    end

    // strobe to memory write port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= filt_valid;                    // one cycle behind window
        end
    end

    // payload follows its strobe
    always_ff @(posedge clk) begin
        if (filt_valid) begin
            wr_addr <= filt_addr;
            wr_row  <= blur_row;
        end
    end

endmodule

// ==== hdl/row_line_buffer.sv ====
`timescale 1ns/1ps

// three-row vertical window over the image
module row_line_buffer (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           shift_en,                // move window down one row
    input  logic           shift_zero,              // load border row of zeros
    input  blur_pkg::row_t row_in,                  // row from image memory
    output blur_pkg::row_t row_above,               // output row - 1
    output blur_pkg::row_t row_mid,                 // output row
    output blur_pkg::row_t row_below                // output row + 1
);

    blur_pkg::row_t row_load;                       // row entering at the bottom

    assign row_load = shift_zero ? '0 : row_in;     // zero-fill at top/bottom edge

    // window registers, oldest row on top
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_above <= '0;
            row_mid   <= '0;
            row_below <= '0;
        end else if (shift_en) begin
            row_above <= row_mid;                   // drop oldest
            row_mid   <= row_below;
            row_below <= row_load;                  // newest row
        end
    end

    // a zero row only makes sense as part of a shift
    a_zero_needs_shift: assert property (
        @(posedge clk) disable iff (!rst_n)
        shift_zero |-> shift_en
    ) else $error("row_line_buffer: shift_zero without shift_en");

endmodule

// ==== hdl/pixel_mem.sv ====
`timescale 1ns/1ps
`include "blur_params.svh"

// row-wide simple dual-port memory
module pixel_mem #(
    parameter int depth = `BLUR_ROWS                // rows held
) (
    input  logic                clk,
    input  logic                we,                 // write strobe
    input  blur_pkg::row_addr_t waddr,              // write row
    input  blur_pkg::row_t      din,                // write data
    input  blur_pkg::row_addr_t raddr,              // read row
    output blur_pkg::row_t      dout                // valid one cycle after raddr
);

    logic [`BLUR_ROW_W-1:0] mem [depth];            // flat row storage

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;                      // whole row at once
        end
    end

    // registered read, no enable
    always_ff @(posedge clk) begin
        dout <= mem[raddr];                         // sampled every cycle
    end

    // rows past depth do not exist, a write there would be lost
    a_waddr_range: assert property (
        @(posedge clk) we |-> (int'(waddr) < depth)
    ) else $error("pixel_mem: write to row %0d beyond depth %0d", waddr, depth);

endmodule

// ==== hdl/blur_pkg.sv ====
`include "blur_params.svh"

package blur_pkg;

    typedef logic [`BLUR_PIX_W-1:0] pixel_t;        // one unsigned pixel

    // column 0 sits in the low bits
    typedef pixel_t [`BLUR_COLS-1:0] row_t;

    typedef logic [`BLUR_ADDR_W-1:0] row_addr_t;    // row index

    // controller sequence
    typedef enum logic [1:0] {
        st_idle  = 2'd0,                            // waiting for start
        st_prime = 2'd1,                            // top border + row 0
        st_blur  = 2'd2,                            // one output row per pass
        st_end   = 2'd3                             // done held here
    } ctrl_state_e;

endpackage

// ==== hdl/blur_params.svh ====
`ifndef BLUR_PARAMS_SVH
`define BLUR_PARAMS_SVH

// image geometry

`define BLUR_COLS 16                            // pixels per row

`define BLUR_ROWS 12                            // rows per image

`define BLUR_PIX_W 8                            // greyscale pixel bits

`define BLUR_ADDR_W 4                           // enough for BLUR_ROWS rows

// one memory word holds a whole image row
`define BLUR_ROW_W (`BLUR_COLS * `BLUR_PIX_W)

// kernel weights 1-2-1 / 2-4-2 / 1-2-1 sum to 16
`define BLUR_KERNEL_SHIFT 4                     // divide by kernel sum

`endif
